//--- logic/glbl_reg_pkg.sv
// Register map and reset values fixed at build time; no strap-driven defaults, one reset domain
package glbl_reg_pkg;

   // ----------------------------------------------------------
   // Bus geometry
   // ----------------------------------------------------------
   localparam int DATA_W    = 32;
   localparam int BYTE_W    = 8;
   localparam int SEL_W     = DATA_W / BYTE_W;
   localparam int ADR_W     = 5;
   localparam int REG_COUNT = 1 << ADR_W;

   typedef logic [DATA_W-1:0] word_t;
   // Read words of the whole map, index = word address
   typedef logic [REG_COUNT-1:0][DATA_W-1:0] reg_array_t;

   // ----------------------------------------------------------
   // Word addresses
   // ----------------------------------------------------------
   localparam logic [ADR_W-1:0] ADR_CHIP_ID    = 5'd0;
   localparam logic [ADR_W-1:0] ADR_RST_CTRL   = 5'd1;
   localparam logic [ADR_W-1:0] ADR_GLBL_CFG   = 5'd2;
   localparam logic [ADR_W-1:0] ADR_INTR_MASK  = 5'd3;
   localparam logic [ADR_W-1:0] ADR_INTR_STAT  = 5'd4;
   localparam logic [ADR_W-1:0] ADR_MULTI_FUNC = 5'd5;
   localparam logic [ADR_W-1:0] ADR_MAILBOX    = 5'd15;
   localparam logic [ADR_W-1:0] ADR_SW_FIRST   = 5'd16;
   localparam logic [ADR_W-1:0] ADR_SW_LAST    = 5'd23;
   localparam int SW_COUNT = int'(ADR_SW_LAST) - int'(ADR_SW_FIRST) + 1;

   // Writable words: 1..5, 15, 16..23
   localparam logic [REG_COUNT-1:0] REG_WR_MAP = 32'h00FF_803E;

   // ----------------------------------------------------------
   // Fixed and reset values
   // ----------------------------------------------------------
   // Manufacturer "RD", two cores, chip 5, rev 1
   localparam word_t CHIP_ID_VALUE      = 32'h8268_2501;
   // CPU interface and QSPI master out of reset
   localparam word_t RST_CTRL_DEFAULT   = 32'h0000_0003;
   // Bit 31 enables the UART master pins
   localparam word_t MULTI_FUNC_DEFAULT = 32'h8000_0000;
   localparam word_t SW_SIGNATURE       = 32'h8273_8343;
   localparam word_t SW_RELEASE_DATE    = 32'h0101_2024;
   localparam word_t SW_REVISION        = 32'h0005_2000;
   // Software bank defaults, entry 0 at ADR_SW_FIRST
   localparam logic [SW_COUNT-1:0][DATA_W-1:0] SW_RESET_VALUES = {
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
      SW_REVISION, SW_RELEASE_DATE, SW_SIGNATURE
   };

   // Stored config bits; 15:4 held the old clock monitor select
   localparam word_t GLBL_CFG_WMASK = 32'hFFFF_000F;
   localparam int CFG_USER_IRQ_LSB  = 0;
   localparam int CFG_SOFT_IRQ      = 3;
   localparam int CFG_RISCV_LSB     = 16;

   // Reset control bits, 1 = block out of reset
   localparam int RST_CPU_INTF = 0;
   localparam int RST_QSPIM    = 1;
   localparam int RST_SSPIM    = 2;
   localparam int RST_UART0    = 3;
   localparam int RST_I2CM     = 4;
   localparam int RST_USB      = 5;
   localparam int RST_UART1    = 6;
   localparam int RST_CPU0     = 8;
   localparam int RST_CPU1     = 9;

   // Interrupt status map, 7:5 reserved
   localparam int IRQ_TIMER_LSB = 0;
   localparam int IRQ_I2CM      = 3;
   localparam int IRQ_USB       = 4;
   localparam int IRQ_GPIO_LSB  = 8;
   localparam word_t IRQ_VALID_MASK = 32'hFFFF_FF1F;

   // Byte lane select widened to a bit mask
   function automatic word_t byte_mask(input logic [SEL_W-1:0] be);
      word_t m;
      for (int i = 0; i < SEL_W; i++) begin
         m[i*BYTE_W +: BYTE_W] = {BYTE_W{be[i]}};
      end
      return m;
   endfunction

   // Replace the selected lanes of a word
   function automatic word_t byte_merge(input word_t old_w, input word_t new_w,
                                        input logic [SEL_W-1:0] be);
      word_t m;
      m = byte_mask(be);
      return (old_w & ~m) | (new_w & m);
   endfunction

endpackage

//--- logic/glbl_bus_slave.sv
// Wishbone classic single-beat slave, no wait states; a held stb restarts one cycle after ack
`timescale 1ns/1ps

module glbl_bus_slave import glbl_reg_pkg::*; (
   input  logic                 mclk,
   input  logic                 s_reset_n,
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  logic [ADR_W-1:0]     adr,
   input  reg_array_t           rd_words,
   input  word_t                mask_word,
   input  word_t                stat_word,
   output logic [REG_COUNT-1:0] wr_sel,
   output word_t                rdata,
   output logic                 ack
);

   logic  pending;
   word_t rd_word;

   // ----------------------------------------------------------
   // Access decode
   // ----------------------------------------------------------
   // Open access, not yet acknowledged
   assign pending = cyc & stb & ~ack;

   // One-hot write strobe, read-only and unmapped words dropped
   always_comb begin
      wr_sel = '0;
      if (pending && we) begin
         wr_sel[adr] = REG_WR_MAP[adr];
      end
   end

   // ----------------------------------------------------------
   // Read path
   // ----------------------------------------------------------
   // Interrupt words live in their own stage
   always_comb begin
      case (adr)
         ADR_INTR_MASK: rd_word = mask_word;
         ADR_INTR_STAT: rd_word = stat_word;
         default:       rd_word = rd_words[adr];
      endcase
   end

   // Ack and data on the commit edge
   // Read word is the pre-write value
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         ack   <= 1'b0;
         rdata <= '0;
      end else if (pending) begin
         ack   <= 1'b1;
         rdata <= rd_word;
      end else begin
         ack   <= 1'b0;
      end
   end

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------
   // Single-cycle ack, even with stb held
   a_ack_single: assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      ack |=> !ack
   ) else $error("ack high on two consecutive cycles");

   // At most one register written per cycle
   a_wr_onehot: assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      $onehot0(wr_sel)
   ) else $error("wr_sel not one-hot");

endmodule

//--- logic/glbl_ctrl_regs.sv
// Control bank under byte-enable writes; interrupt words 3 and 4 read as zero here
`timescale 1ns/1ps

module glbl_ctrl_regs import glbl_reg_pkg::*; (
   input  logic                 mclk,
   input  logic                 s_reset_n,
   input  logic [REG_COUNT-1:0] wr_sel,
   input  word_t                wdata,
   input  logic [SEL_W-1:0]     sel,
   output reg_array_t           rd_words,
   output logic [1:0]           cpu_core_rst_n,
   output logic                 cpu_intf_rst_n,
   output logic                 qspim_rst_n,
   output logic                 sspim_rst_n,
   output logic [1:0]           uart_rst_n,
   output logic                 i2cm_rst_n,
   output logic                 usb_rst_n,
   output logic                 soft_irq,
   output logic [2:0]           user_irq,
   output logic [15:0]          cfg_riscv_ctrl,
   output word_t                cfg_multi_func_sel
);

   word_t rst_ctrl;
   word_t glbl_cfg;
   word_t multi_func;
   word_t mailbox;
   word_t sw_reg [SW_COUNT];

   // ----------------------------------------------------------
   // Global registers
   // ----------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_ctrl   <= RST_CTRL_DEFAULT;
         glbl_cfg   <= '0;
         multi_func <= MULTI_FUNC_DEFAULT;
         mailbox    <= '0;
      end else begin
         if (wr_sel[ADR_RST_CTRL]) begin
            rst_ctrl <= byte_merge(rst_ctrl, wdata, sel);
         end
         // Only the masked bits have flops behind them
         if (wr_sel[ADR_GLBL_CFG]) begin
            glbl_cfg <= byte_merge(glbl_cfg, wdata, sel) & GLBL_CFG_WMASK;
         end
         if (wr_sel[ADR_MULTI_FUNC]) begin
            multi_func <= byte_merge(multi_func, wdata, sel);
         end
         // Mailbox shared between the two cores
         if (wr_sel[ADR_MAILBOX]) begin
            mailbox <= byte_merge(mailbox, wdata, sel);
         end
      end
   end

   // ----------------------------------------------------------
   // Software bank
   // ----------------------------------------------------------
   // Signature, release date, revision, then scratch
   for (genvar i = 0; i < SW_COUNT; i++) begin : g_sw
      always_ff @(posedge mclk or negedge s_reset_n) begin
         if (!s_reset_n) begin
            sw_reg[i] <= SW_RESET_VALUES[i];
         end else if (wr_sel[int'(ADR_SW_FIRST) + i]) begin
            sw_reg[i] <= byte_merge(sw_reg[i], wdata, sel);
         end
      end
   end

   // ----------------------------------------------------------
   // Read words
   // ----------------------------------------------------------
   // Unmapped entries stay zero
   always_comb begin
      rd_words                 = '0;
      rd_words[ADR_CHIP_ID]    = CHIP_ID_VALUE;
      rd_words[ADR_RST_CTRL]   = rst_ctrl;
      rd_words[ADR_GLBL_CFG]   = glbl_cfg;
      rd_words[ADR_MULTI_FUNC] = multi_func;
      rd_words[ADR_MAILBOX]    = mailbox;
      for (int i = 0; i < SW_COUNT; i++) begin
         rd_words[int'(ADR_SW_FIRST) + i] = sw_reg[i];
      end
   end

   // ----------------------------------------------------------
   // Control outputs
   // ----------------------------------------------------------
   // Reset lines, active low
   assign cpu_intf_rst_n    = rst_ctrl[RST_CPU_INTF];
   assign qspim_rst_n       = rst_ctrl[RST_QSPIM];
   assign sspim_rst_n       = rst_ctrl[RST_SSPIM];
   assign uart_rst_n[0]     = rst_ctrl[RST_UART0];
   assign uart_rst_n[1]     = rst_ctrl[RST_UART1];
   assign i2cm_rst_n        = rst_ctrl[RST_I2CM];
   assign usb_rst_n         = rst_ctrl[RST_USB];
   assign cpu_core_rst_n[0] = rst_ctrl[RST_CPU0];
   assign cpu_core_rst_n[1] = rst_ctrl[RST_CPU1];

   // Config fields
   assign user_irq       = glbl_cfg[CFG_USER_IRQ_LSB +: 3];
   assign soft_irq       = glbl_cfg[CFG_SOFT_IRQ];
   assign cfg_riscv_ctrl = glbl_cfg[CFG_RISCV_LSB +: 16];

   // Pin mux select straight from the register
   assign cfg_multi_func_sel = multi_func;

   // Chip ID is read-only, decode must never strobe it
   a_no_id_write: assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      !wr_sel[ADR_CHIP_ID]
   ) else $error("write select on chip ID");

endmodule

//--- logic/glbl_intr_stat.sv
// Sticky status is level-set every cycle a request is high; a set beats a same-cycle clear
`timescale 1ns/1ps

module glbl_intr_stat import glbl_reg_pkg::*; (
   input  logic             mclk,
   input  logic             s_reset_n,
   input  logic             wr_mask,
   input  logic             wr_stat,
   input  word_t            wdata,
   input  logic [SEL_W-1:0] sel,
   input  logic [2:0]       timer_intr,
   input  logic             i2cm_intr,
   input  logic             usb_intr,
   input  logic [31:0]      gpio_intr,
   output word_t            mask_word,
   output word_t            stat_word,
   output word_t            irq_lines
);

   word_t hw_req;
   word_t clr_bits;

   // ----------------------------------------------------------
   // Request map
   // ----------------------------------------------------------
   // GPIO 7:0 is port A, not routed to the CPU
   always_comb begin
      hw_req                          = '0;
      hw_req[IRQ_TIMER_LSB +: 3]      = timer_intr;
      hw_req[IRQ_I2CM]                = i2cm_intr;
      hw_req[IRQ_USB]                 = usb_intr;
      hw_req[DATA_W-1:IRQ_GPIO_LSB]   = gpio_intr[DATA_W-1:IRQ_GPIO_LSB];
   end

   // Write 1 to clear, selected lanes only
   assign clr_bits = wr_stat ? (wdata & byte_mask(sel)) : '0;

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         stat_word <= '0;
         mask_word <= '0;
      end else begin
         stat_word <= (stat_word & ~clr_bits) | hw_req;
         if (wr_mask) begin
            mask_word <= byte_merge(mask_word, wdata, sel);
         end
      end
   end

   // Masked lines to the CPU
   assign irq_lines = mask_word & stat_word;

   // Reserved status bits never set
   a_rsvd_zero: assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      (stat_word & ~IRQ_VALID_MASK) == '0
   ) else $error("reserved status bit set");

endmodule

//--- logic/glbl_reg.sv
// Global register block top; all state on s_reset_n, clock generation and straps not included
`timescale 1ns/1ps

module glbl_reg import glbl_reg_pkg::*; (
   input  logic             mclk,
   input  logic             s_reset_n,

   // Wishbone slave
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  logic [ADR_W-1:0] adr,
   input  word_t            wdata,
   input  logic [SEL_W-1:0] sel,
   output word_t            rdata,
   output logic             ack,

   // Interrupt requests
   input  logic [2:0]       timer_intr,
   input  logic             i2cm_intr,
   input  logic             usb_intr,
   input  logic [31:0]      gpio_intr,

   // Block resets
   output logic [1:0]       cpu_core_rst_n,
   output logic             cpu_intf_rst_n,
   output logic             qspim_rst_n,
   output logic             sspim_rst_n,
   output logic [1:0]       uart_rst_n,
   output logic             i2cm_rst_n,
   output logic             usb_rst_n,

   // CPU configuration
   output logic             soft_irq,
   output logic [2:0]       user_irq,
   output logic [15:0]      cfg_riscv_ctrl,
   output word_t            cfg_multi_func_sel,
   output word_t            irq_lines
);

   logic [REG_COUNT-1:0] wr_sel;
   reg_array_t           rd_words;
   word_t                mask_word;
   word_t                stat_word;

   // ----------------------------------------------------------
   // Bus front end
   // ----------------------------------------------------------
   glbl_bus_slave u_bus (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .rd_words  (rd_words),
      .mask_word (mask_word),
      .stat_word (stat_word),
      .wr_sel    (wr_sel),
      .rdata     (rdata),
      .ack       (ack)
   );

   // ----------------------------------------------------------
   // Register stages
   // ----------------------------------------------------------
   glbl_ctrl_regs u_ctrl (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .wr_sel             (wr_sel),
      .wdata              (wdata),
      .sel                (sel),
      .rd_words           (rd_words),
      .cpu_core_rst_n     (cpu_core_rst_n),
      .cpu_intf_rst_n     (cpu_intf_rst_n),
      .qspim_rst_n        (qspim_rst_n),
      .sspim_rst_n        (sspim_rst_n),
      .uart_rst_n         (uart_rst_n),
      .i2cm_rst_n         (i2cm_rst_n),
      .usb_rst_n          (usb_rst_n),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_multi_func_sel (cfg_multi_func_sel)
   );

   // Mask and status strobes tapped from the decode
   glbl_intr_stat u_intr (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .wr_mask    (wr_sel[ADR_INTR_MASK]),
      .wr_stat    (wr_sel[ADR_INTR_STAT]),
      .wdata      (wdata),
      .sel        (sel),
      .timer_intr (timer_intr),
      .i2cm_intr  (i2cm_intr),
      .usb_intr   (usb_intr),
      .gpio_intr  (gpio_intr),
      .mask_word  (mask_word),
      .stat_word  (stat_word),
      .irq_lines  (irq_lines)
   );

endmodule

//--- verif/glbl_tb_tasks.svh
// Included inside glbl_reg_tb after its signals; bus driven on falling mclk, single-beat only
`ifndef GLBL_TB_TASKS_SVH
`define GLBL_TB_TASKS_SVH

localparam int          ACK_TIMEOUT = 16;
localparam logic [31:0] RAND_SEED   = 32'h0a79c86f;

logic [31:0] rand_state = RAND_SEED;

// ----------------------------------------------------------
// Failure and compare
// ----------------------------------------------------------
task automatic abort_run(input string why);
   $display("%s", why);
   $display("TEST FAILED");
   $fatal(1, "run aborted");
endtask

// First mismatch ends the run
task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
   if (got !== expv) begin
      abort_run($sformatf("ERR time=%0t %s got=0x%08h exp=0x%08h", $time, name, got, expv));
   end
endtask

// LCG, 32-bit state
function automatic logic [31:0] next_rand();
   rand_state = rand_state * 32'd1664525 + 32'd1013904223;
   return rand_state;
endfunction

// ----------------------------------------------------------
// Wishbone master
// ----------------------------------------------------------
// Ack seen on a falling edge, bounded
task automatic wait_ack(input string kind);
   int cycles;
   cycles = 0;
   do begin
      @(negedge mclk);
      cycles++;
   end while (!ack && cycles < ACK_TIMEOUT);
   if (!ack) begin
      abort_run($sformatf("Bus %s at address %0d got no ack in %0d cycles", kind, adr, cycles));
   end
endtask

task automatic wb_write(input logic [ADR_W-1:0] a, input word_t d, input logic [SEL_W-1:0] s);
   @(negedge mclk);
   cyc   = 1'b1;
   stb   = 1'b1;
   we    = 1'b1;
   adr   = a;
   wdata = d;
   sel   = s;
   wait_ack("write");
   // Drop stb in the ack cycle
   cyc = 1'b0;
   stb = 1'b0;
   we  = 1'b0;
endtask

task automatic wb_read(input logic [ADR_W-1:0] a, output word_t d);
   @(negedge mclk);
   cyc = 1'b1;
   stb = 1'b1;
   we  = 1'b0;
   adr = a;
   wait_ack("read");
   d   = rdata;
   cyc = 1'b0;
   stb = 1'b0;
endtask

`endif

//--- verif/glbl_reg_tb.sv
// Directed bench for glbl_reg; every failure stops at once, stimulus from a fixed-seed LCG
`timescale 1ns/1ps

module glbl_reg_tb import glbl_reg_pkg::*; ();

   // DUT ports, names match for the .* hookup
   logic             mclk;
   logic             s_reset_n;
   logic             cyc;
   logic             stb;
   logic             we;
   logic [ADR_W-1:0] adr;
   word_t            wdata;
   logic [SEL_W-1:0] sel;
   word_t            rdata;
   logic             ack;
   logic [2:0]       timer_intr;
   logic             i2cm_intr;
   logic             usb_intr;
   logic [31:0]      gpio_intr;
   logic [1:0]       cpu_core_rst_n;
   logic             cpu_intf_rst_n;
   logic             qspim_rst_n;
   logic             sspim_rst_n;
   logic [1:0]       uart_rst_n;
   logic             i2cm_rst_n;
   logic             usb_rst_n;
   logic             soft_irq;
   logic [2:0]       user_irq;
   logic [15:0]      cfg_riscv_ctrl;
   word_t            cfg_multi_func_sel;
   word_t            irq_lines;

   // Expected word per address
   word_t exp_word [REG_COUNT];

   `include "glbl_tb_tasks.svh"

   glbl_reg glbl_reg_i (.*);

   // 40 ns clock
   initial begin
      mclk = 1'b0;
      forever #20 mclk = ~mclk;
   end

   // ----------------------------------------------------------
   // Reference helpers
   // ----------------------------------------------------------
   // Selected byte lanes take the new data
   function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                         input logic [SEL_W-1:0] s);
      word_t r;
      r = old_w;
      for (int i = 0; i < SEL_W; i++) begin
         if (s[i]) begin
            r[i*8 +: 8] = new_w[i*8 +: 8];
         end
      end
      return r;
   endfunction

   // Status bit map: timer 2:0, I2C 3, USB 4, GPIO 31:8
   function automatic word_t irq_bits(input logic [2:0] t, input logic i, input logic u,
                                      input word_t g);
      word_t r;
      r                      = g & 32'hFFFF_FF00;
      r[IRQ_TIMER_LSB +: 3]  = t;
      r[IRQ_I2CM]            = i;
      r[IRQ_USB]             = u;
      return r;
   endfunction

   task automatic read_expect(input logic [ADR_W-1:0] a);
      word_t got;
      wb_read(a, got);
      check($sformatf("rdata@%0d", a), got, exp_word[a]);
   endtask

   task automatic check_rst_lines(input word_t w);
      check("cpu_intf_rst_n", 32'(cpu_intf_rst_n), 32'(w[RST_CPU_INTF]));
      check("qspim_rst_n", 32'(qspim_rst_n), 32'(w[RST_QSPIM]));
      check("sspim_rst_n", 32'(sspim_rst_n), 32'(w[RST_SSPIM]));
      check("uart_rst_n[0]", 32'(uart_rst_n[0]), 32'(w[RST_UART0]));
      check("uart_rst_n[1]", 32'(uart_rst_n[1]), 32'(w[RST_UART1]));
      check("i2cm_rst_n", 32'(i2cm_rst_n), 32'(w[RST_I2CM]));
      check("usb_rst_n", 32'(usb_rst_n), 32'(w[RST_USB]));
      check("cpu_core_rst_n[0]", 32'(cpu_core_rst_n[0]), 32'(w[RST_CPU0]));
      check("cpu_core_rst_n[1]", 32'(cpu_core_rst_n[1]), 32'(w[RST_CPU1]));
   endtask

   // One-cycle request pulse, sets status at the edge between
   task automatic pulse_requests(input logic [2:0] t, input logic i, input logic u,
                                 input word_t g);
      @(negedge mclk);
      timer_intr = t;
      i2cm_intr  = i;
      usb_intr   = u;
      gpio_intr  = g;
      @(negedge mclk);
      timer_intr = '0;
      i2cm_intr  = 1'b0;
      usb_intr   = 1'b0;
      gpio_intr  = '0;
   endtask

   // ----------------------------------------------------------
   // Directed tests
   // ----------------------------------------------------------
   task automatic verify_reset_values();
      for (int a = 0; a < REG_COUNT; a++) begin
         exp_word[a] = '0;
      end
      exp_word[ADR_CHIP_ID]         = CHIP_ID_VALUE;
      exp_word[ADR_RST_CTRL]        = 32'h0000_0003;
      exp_word[ADR_MULTI_FUNC]      = 32'h8000_0000;
      exp_word[ADR_SW_FIRST]        = SW_SIGNATURE;
      exp_word[ADR_SW_FIRST + 5'd1] = SW_RELEASE_DATE;
      exp_word[ADR_SW_FIRST + 5'd2] = SW_REVISION;
      check("ack", 32'(ack), 32'h0);
      check("rdata", rdata, 32'h0);
      check_rst_lines(32'h0000_0003);
      check("soft_irq", 32'(soft_irq), 32'h0);
      check("user_irq", 32'(user_irq), 32'h0);
      check("cfg_riscv_ctrl", 32'(cfg_riscv_ctrl), 32'h0);
      check("irq_lines", irq_lines, 32'h0);
      check("cfg_multi_func_sel", cfg_multi_func_sel, 32'h8000_0000);
      // Kept map: 0 to 5, mailbox, software bank
      for (int a = 0; a < REG_COUNT; a++) begin
         if (a <= 5 || (a >= 15 && a <= 23)) begin
            read_expect(5'(a));
         end
      end
   endtask

   task automatic storage_and_byte_enables();
      word_t            d;
      logic [SEL_W-1:0] s;
      repeat (3) begin
         for (int a = int'(ADR_MAILBOX); a <= int'(ADR_SW_LAST); a++) begin
            d = next_rand();
            s = SEL_W'(next_rand());
            wb_write(5'(a), d, s);
            exp_word[a] = merge_lanes(exp_word[a], d, s);
            read_expect(5'(a));
         end
      end
      // Chip ID and holes ignore writes
      for (int a = 0; a < REG_COUNT; a++) begin
         if (a == 0 || (a >= 6 && a <= 14) || a >= 24) begin
            wb_write(5'(a), next_rand(), 4'hF);
         end
      end
      for (int a = 0; a < REG_COUNT; a++) begin
         read_expect(5'(a));
      end
   endtask

   task automatic reset_control_lines();
      word_t pat [6];
      pat = '{32'h0, 32'hFFFF_FFFF, 32'h0000_0155, 32'h0000_02AA, next_rand(), next_rand()};
      foreach (pat[i]) begin
         wb_write(ADR_RST_CTRL, pat[i], 4'hF);
         exp_word[ADR_RST_CTRL] = pat[i];
         check_rst_lines(pat[i]);
         read_expect(ADR_RST_CTRL);
      end
      // Lane 1 only, CPU core resets
      wb_write(ADR_RST_CTRL, 32'hFFFF_FFFF, 4'b0010);
      exp_word[ADR_RST_CTRL] = merge_lanes(exp_word[ADR_RST_CTRL], 32'hFFFF_FFFF, 4'b0010);
      check_rst_lines(exp_word[ADR_RST_CTRL]);
      read_expect(ADR_RST_CTRL);
   endtask

   task automatic global_config();
      word_t            pat [4];
      logic [SEL_W-1:0] s;
      pat = '{32'hFFFF_FFFF, 32'h1234_5678, next_rand(), next_rand()};
      foreach (pat[i]) begin
         s = (i < 2) ? 4'hF : SEL_W'(next_rand());
         wb_write(ADR_GLBL_CFG, pat[i], s);
         exp_word[ADR_GLBL_CFG] = merge_lanes(exp_word[ADR_GLBL_CFG], pat[i], s)
                                  & GLBL_CFG_WMASK;
         check("soft_irq", 32'(soft_irq), 32'(exp_word[ADR_GLBL_CFG][CFG_SOFT_IRQ]));
         check("user_irq", 32'(user_irq), 32'(exp_word[ADR_GLBL_CFG][CFG_USER_IRQ_LSB +: 3]));
         check("cfg_riscv_ctrl", 32'(cfg_riscv_ctrl),
               32'(exp_word[ADR_GLBL_CFG][CFG_RISCV_LSB +: 16]));
         read_expect(ADR_GLBL_CFG);
      end
   endtask

   task automatic multi_func_select();
      word_t            d;
      logic [SEL_W-1:0] s;
      repeat (4) begin
         d = next_rand();
         s = SEL_W'(next_rand());
         wb_write(ADR_MULTI_FUNC, d, s);
         exp_word[ADR_MULTI_FUNC] = merge_lanes(exp_word[ADR_MULTI_FUNC], d, s);
         check("cfg_multi_func_sel", cfg_multi_func_sel, exp_word[ADR_MULTI_FUNC]);
         read_expect(ADR_MULTI_FUNC);
      end
   endtask

   task automatic interrupt_status();
      word_t stat;
      word_t mask;
      word_t got;
      stat = '0;
      pulse_requests(3'b101, 1'b1, 1'b0, 32'hDEAD_BEEF);
      stat |= irq_bits(3'b101, 1'b1, 1'b0, 32'hDEAD_BEEF);
      // GPIO 7:0 has no status bit
      pulse_requests(3'b010, 1'b0, 1'b1, 32'h0000_00FF);
      stat |= irq_bits(3'b010, 1'b0, 1'b1, 32'h0000_00FF);
      wb_read(ADR_INTR_STAT, got);
      check("rdata@4", got, stat);
      mask = 32'h0F0F_F01A;
      wb_write(ADR_INTR_MASK, mask, 4'hF);
      wb_write(ADR_INTR_MASK, 32'hFFFF_FFFF, 4'b1000);
      mask = merge_lanes(mask, 32'hFFFF_FFFF, 4'b1000);
      exp_word[ADR_INTR_MASK] = mask;
      read_expect(ADR_INTR_MASK);
      check("irq_lines", irq_lines, mask & stat);
      // Write 1 to clear, lanes 0 and 2 only
      wb_write(ADR_INTR_STAT, 32'hFFFF_FFFF, 4'b0101);
      stat &= ~32'h00FF_00FF;
      wb_read(ADR_INTR_STAT, got);
      check("rdata@4", got, stat);
      check("irq_lines", irq_lines, mask & stat);
      // Held requests survive a full clear
      @(negedge mclk);
      timer_intr = 3'b001;
      gpio_intr  = 32'h8000_0000;
      wb_write(ADR_INTR_STAT, 32'hFFFF_FFFF, 4'hF);
      // Released in the ack cycle so the bits rely on set beating clear
      timer_intr = '0;
      gpio_intr  = '0;
      stat = irq_bits(3'b001, 1'b0, 1'b0, 32'h8000_0000);
      wb_read(ADR_INTR_STAT, got);
      check("rdata@4", got, stat);
      check("irq_lines", irq_lines, mask & stat);
      wb_write(ADR_INTR_STAT, 32'hFFFF_FFFF, 4'hF);
      wb_read(ADR_INTR_STAT, got);
      check("rdata@4", got, 32'h0);
      check("irq_lines", irq_lines, 32'h0);
   endtask

   // ----------------------------------------------------------
   // Sequence
   // ----------------------------------------------------------
   initial begin
      s_reset_n  = 1'b0;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      wdata      = '0;
      sel        = '0;
      timer_intr = '0;
      i2cm_intr  = 1'b0;
      usb_intr   = 1'b0;
      gpio_intr  = '0;
      repeat (8) @(negedge mclk);
      s_reset_n = 1'b1;
      verify_reset_values();
      storage_and_byte_enables();
      reset_control_lines();
      global_config();
      multi_func_select();
      interrupt_status();
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+verif
logic/glbl_reg_pkg.sv
logic/glbl_bus_slave.sv
logic/glbl_ctrl_regs.sv
logic/glbl_intr_stat.sv
logic/glbl_reg.sv
verif/glbl_reg_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; a $fatal in the bench gives a non-zero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module glbl_reg_tb -f vlog.f -o glbl_reg_sim
./obj_dir/glbl_reg_sim
